/* hw/idma_rt_pkg.sv */
// constants and bus types for the two-port 2d DMA register front end
// offsets are byte addresses of 32-bit words; only exact word offsets are decoded
package idma_rt_pkg;

  // the module tree is built for exactly two register ports
  localparam int unsigned NumPorts     = 2;
  localparam int unsigned PortIdxWidth = $clog2(NumPorts);

  localparam int unsigned RegWidth     = 32;
  localparam int unsigned IdWidth      = 32;
  localparam int unsigned RegAddrWidth = 8;

  // register map
  localparam logic [RegAddrWidth-1:0] RegSrcAddr   = 8'h00;
  localparam logic [RegAddrWidth-1:0] RegDstAddr   = 8'h04;
  localparam logic [RegAddrWidth-1:0] RegNumBytes  = 8'h08;
  localparam logic [RegAddrWidth-1:0] RegConf      = 8'h0C;
  localparam logic [RegAddrWidth-1:0] RegStrideSrc = 8'h10;
  localparam logic [RegAddrWidth-1:0] RegStrideDst = 8'h14;
  localparam logic [RegAddrWidth-1:0] RegNumReps   = 8'h18;
  // read-only, a read here launches a transfer
  localparam logic [RegAddrWidth-1:0] RegNextId    = 8'h1C;
  localparam logic [RegAddrWidth-1:0] RegDone      = 8'h20;
  localparam logic [RegAddrWidth-1:0] RegStatus    = 8'h24;

  // option bits inside RegConf
  localparam int unsigned ConfWidth       = 3;
  localparam int unsigned ConfDecoupleBit = 0;
  localparam int unsigned ConfDeburstBit  = 1;
  localparam int unsigned ConfTwodBit     = 2;

  // master holds the request until it sees ready
  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [RegAddrWidth-1:0] addr;
    logic [RegWidth-1:0]     wdata;
  } reg_req_t;

  typedef struct packed {
    logic                ready;
    logic                error;
    logic [RegWidth-1:0] rdata;
  } reg_rsp_t;

  // one 2d transfer as handed to the backend
  typedef struct packed {
    logic [RegWidth-1:0] src_addr;
    logic [RegWidth-1:0] dst_addr;
    logic [RegWidth-1:0] length;
    logic [RegWidth-1:0] src_stride;
    logic [RegWidth-1:0] dst_stride;
    logic [RegWidth-1:0] reps;
    logic                decouple_rw;
    logic                deburst;
  } burst_req_t;

endpackage

/* hw/idma_burst_arbiter.sv */
// round-robin arbiter with lock-in; a requester must hold req_i until it is granted
// payload_t must be a packed type
`timescale 1ns/10ps

module idma_burst_arbiter #(
  parameter type payload_t = logic
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic     [idma_rt_pkg::NumPorts-1:0]  req_i,
  input  payload_t [idma_rt_pkg::NumPorts-1:0]  data_i,
  input  logic                                  ready_i,
  output logic     [idma_rt_pkg::NumPorts-1:0]  gnt_o,
  output logic                                  valid_o,
  output payload_t                              data_o
);

  logic [idma_rt_pkg::PortIdxWidth-1:0] rr_q;
  logic [idma_rt_pkg::PortIdxWidth-1:0] rr_sel;
  logic [idma_rt_pkg::PortIdxWidth-1:0] lock_idx_q;
  logic [idma_rt_pkg::PortIdxWidth-1:0] sel;
  logic                                 lock_q;
  logic                                 accept;

  // walk from the lowest priority up so the port at rr_q wins last
  always_comb begin
    int cand;
    rr_sel = rr_q;
    for (int i = idma_rt_pkg::NumPorts - 1; i >= 0; i--) begin
      cand = (int'(rr_q) + i) % int'(idma_rt_pkg::NumPorts);
      if (req_i[cand]) begin
        rr_sel = idma_rt_pkg::PortIdxWidth'(cand);
      end
    end
  end

  // a presented request keeps its port until it is taken
  assign sel     = lock_q ? lock_idx_q : rr_sel;
  assign valid_o = req_i[sel];
  assign data_o  = data_i[sel];
  assign accept  = valid_o & ready_i;

  always_comb begin
    for (int i = 0; i < idma_rt_pkg::NumPorts; i++) begin
      gnt_o[i] = accept && (sel == idma_rt_pkg::PortIdxWidth'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (accept) begin
      lock_q <= 1'b0;
      // next round starts just past the winner
      if (sel == idma_rt_pkg::PortIdxWidth'(idma_rt_pkg::NumPorts - 1)) begin
        rr_q <= '0;
      end else begin
        rr_q <= sel + 1'b1;
      end
    end else begin
      lock_q     <= valid_o;
      lock_idx_q <= sel;
    end
  end

endmodule

/* hw/idma_transfer_id_gen.sv */
// issued and completed transfer counters, both wrap at IdWidth bits
`timescale 1ns/10ps

module idma_transfer_id_gen (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            issue_i,
  input  logic                            retire_i,
  output logic [idma_rt_pkg::IdWidth-1:0] next_o,
  output logic [idma_rt_pkg::IdWidth-1:0] completed_o
);

  logic [idma_rt_pkg::IdWidth-1:0] next_q;
  logic [idma_rt_pkg::IdWidth-1:0] completed_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // id 0 is never handed out, so done_id 0 means nothing finished yet
      next_q      <= idma_rt_pkg::IdWidth'(1);
      completed_q <= '0;
    end else begin
      if (issue_i) begin
        next_q <= next_q + 1'b1;
      end
      if (retire_i) begin
        completed_q <= completed_q + 1'b1;
      end
    end
  end

  assign next_o      = next_q;
  assign completed_o = completed_q;

endmodule

/* hw/idma_rt_reg_file.sv */
// configuration registers of one port; RegConf stores its three option bits only
// a launching RegNextId read keeps ready low until the arbiter grants it
`timescale 1ns/10ps

module idma_rt_reg_file (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  idma_rt_pkg::reg_req_t           reg_req_i,
  input  logic                            launch_grant_i,
  input  logic [idma_rt_pkg::IdWidth-1:0] next_id_i,
  input  logic [idma_rt_pkg::IdWidth-1:0] done_id_i,
  input  logic                            busy_i,
  output idma_rt_pkg::reg_rsp_t           reg_rsp_o,
  output logic                            launch_valid_o,
  output idma_rt_pkg::burst_req_t         burst_o
);

  logic [idma_rt_pkg::RegWidth-1:0]  src_addr_q;
  logic [idma_rt_pkg::RegWidth-1:0]  dst_addr_q;
  logic [idma_rt_pkg::RegWidth-1:0]  num_bytes_q;
  logic [idma_rt_pkg::ConfWidth-1:0] conf_q;
  logic [idma_rt_pkg::RegWidth-1:0]  stride_src_q;
  logic [idma_rt_pkg::RegWidth-1:0]  stride_dst_q;
  logic [idma_rt_pkg::RegWidth-1:0]  num_reps_q;

  logic                             rd;
  logic                             wr;
  logic                             writable;
  logic                             known;
  logic                             launchable;
  logic [idma_rt_pkg::RegWidth-1:0] rd_value;

  assign rd = reg_req_i.valid & ~reg_req_i.write;
  assign wr = reg_req_i.valid & reg_req_i.write;

  // nothing to move without a length, and a 2d transfer needs repetitions
  assign launchable = (num_bytes_q != '0) &&
                      (!conf_q[idma_rt_pkg::ConfTwodBit] || (num_reps_q != '0));

  assign launch_valid_o = rd && (reg_req_i.addr == idma_rt_pkg::RegNextId) && launchable;

  // address decode and read mux
  always_comb begin
    writable = 1'b1;
    known    = 1'b1;
    rd_value = '0;
    case (reg_req_i.addr)
      idma_rt_pkg::RegSrcAddr:   rd_value = src_addr_q;
      idma_rt_pkg::RegDstAddr:   rd_value = dst_addr_q;
      idma_rt_pkg::RegNumBytes:  rd_value = num_bytes_q;
      idma_rt_pkg::RegConf:      rd_value = {{(idma_rt_pkg::RegWidth-idma_rt_pkg::ConfWidth){1'b0}},
                                             conf_q};
      idma_rt_pkg::RegStrideSrc: rd_value = stride_src_q;
      idma_rt_pkg::RegStrideDst: rd_value = stride_dst_q;
      idma_rt_pkg::RegNumReps:   rd_value = num_reps_q;
      // returns zero when the configuration cannot launch
      idma_rt_pkg::RegNextId:    writable = 1'b0;
      idma_rt_pkg::RegDone: begin
        writable = 1'b0;
        rd_value = done_id_i;
      end
      idma_rt_pkg::RegStatus: begin
        writable = 1'b0;
        rd_value = {{(idma_rt_pkg::RegWidth-1){1'b0}}, busy_i};
      end
      default: begin
        writable = 1'b0;
        known    = 1'b0;
      end
    endcase
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    if (wr && !writable) begin
      reg_rsp_o.error = 1'b1;
    end
    if (rd) begin
      if (!known) begin
        reg_rsp_o.error = 1'b1;
      end else if (launch_valid_o) begin
        // stall until the backend takes the burst, then hand back its id
        reg_rsp_o.ready = launch_grant_i;
        reg_rsp_o.rdata = next_id_i;
      end else begin
        reg_rsp_o.rdata = rd_value;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_addr_q   <= '0;
      dst_addr_q   <= '0;
      num_bytes_q  <= '0;
      conf_q       <= '0;
      stride_src_q <= '0;
      stride_dst_q <= '0;
      num_reps_q   <= '0;
    end else if (wr) begin
      case (reg_req_i.addr)
        idma_rt_pkg::RegSrcAddr:   src_addr_q   <= reg_req_i.wdata;
        idma_rt_pkg::RegDstAddr:   dst_addr_q   <= reg_req_i.wdata;
        idma_rt_pkg::RegNumBytes:  num_bytes_q  <= reg_req_i.wdata;
        idma_rt_pkg::RegConf:      conf_q       <= reg_req_i.wdata[idma_rt_pkg::ConfWidth-1:0];
        idma_rt_pkg::RegStrideSrc: stride_src_q <= reg_req_i.wdata;
        idma_rt_pkg::RegStrideDst: stride_dst_q <= reg_req_i.wdata;
        idma_rt_pkg::RegNumReps:   num_reps_q   <= reg_req_i.wdata;
        default: ;
      endcase
    end
  end

  // burst built straight from the registers
  always_comb begin
    burst_o.src_addr    = src_addr_q;
    burst_o.dst_addr    = dst_addr_q;
    burst_o.length      = num_bytes_q;
    burst_o.src_stride  = stride_src_q;
    burst_o.dst_stride  = stride_dst_q;
    burst_o.decouple_rw = conf_q[idma_rt_pkg::ConfDecoupleBit];
    burst_o.deburst     = conf_q[idma_rt_pkg::ConfDeburstBit];
    if (conf_q[idma_rt_pkg::ConfTwodBit]) begin
      burst_o.reps = num_reps_q;
    end else begin
      // a 1d transfer is a single repetition
      burst_o.reps = idma_rt_pkg::RegWidth'(1);
    end
  end

endmodule

/* hw/idma_rt_frontend.sv */
// two register ports feeding one backend burst stream, valid/ready toward the backend
// trans_complete_i is expected as a one-cycle pulse per finished transfer
`timescale 1ns/10ps

module idma_rt_frontend (
  input  logic                                               clk_i,
  input  logic                                               reset_i,
  input  idma_rt_pkg::reg_req_t [idma_rt_pkg::NumPorts-1:0]  reg_req_i,
  input  logic                                               ready_i,
  input  logic                                               backend_idle_i,
  input  logic                                               trans_complete_i,
  output idma_rt_pkg::reg_rsp_t [idma_rt_pkg::NumPorts-1:0]  reg_rsp_o,
  output idma_rt_pkg::burst_req_t                            burst_req_o,
  output logic                                               valid_o
);

  logic [idma_rt_pkg::NumPorts-1:0]                    launch_valid;
  logic [idma_rt_pkg::NumPorts-1:0]                    launch_grant;
  idma_rt_pkg::burst_req_t [idma_rt_pkg::NumPorts-1:0] port_burst;
  logic [idma_rt_pkg::IdWidth-1:0]                     next_id;
  logic [idma_rt_pkg::IdWidth-1:0]                     done_id;
  logic                                                busy;
  logic                                                issue;

  assign busy = ~backend_idle_i;

  // a grant is exactly one backend acceptance
  assign issue = |launch_grant;

  for (genvar i = 0; i < idma_rt_pkg::NumPorts; i++) begin : gen_ports
    idma_rt_reg_file i_reg_file (
      .clk_i          ( clk_i           ),
      .reset_i        ( reset_i         ),
      .reg_req_i      ( reg_req_i[i]    ),
      .launch_grant_i ( launch_grant[i] ),
      .next_id_i      ( next_id         ),
      .done_id_i      ( done_id         ),
      .busy_i         ( busy            ),
      .reg_rsp_o      ( reg_rsp_o[i]    ),
      .launch_valid_o ( launch_valid[i] ),
      .burst_o        ( port_burst[i]   )
    );
  end

  idma_burst_arbiter #(
    .payload_t ( idma_rt_pkg::burst_req_t )
  ) i_burst_arbiter (
    .clk_i   ( clk_i        ),
    .reset_i ( reset_i      ),
    .req_i   ( launch_valid ),
    .data_i  ( port_burst   ),
    .ready_i ( ready_i      ),
    .gnt_o   ( launch_grant ),
    .valid_o ( valid_o      ),
    .data_o  ( burst_req_o  )
  );

  idma_transfer_id_gen i_transfer_id_gen (
    .clk_i       ( clk_i            ),
    .reset_i     ( reset_i          ),
    .issue_i     ( issue            ),
    .retire_i    ( trans_complete_i ),
    .next_o      ( next_id          ),
    .completed_o ( done_id          )
  );

endmodule

/* test/idma_rt_frontend_chk.sv */
// concurrent checks on the backend handshake and the register responses
// bound into idma_rt_frontend from the testbench
`timescale 1ns/10ps

module idma_rt_frontend_chk (
  input logic                                              clk_i,
  input logic                                              reset_i,
  input logic                                              ready_i,
  input logic                                              valid_i,
  input idma_rt_pkg::burst_req_t                           burst_i,
  input logic [idma_rt_pkg::NumPorts-1:0]                  grant_i,
  input idma_rt_pkg::reg_req_t [idma_rt_pkg::NumPorts-1:0] req_i,
  input idma_rt_pkg::reg_rsp_t [idma_rt_pkg::NumPorts-1:0] rsp_i
);

  // a presented burst stays up and unchanged until the backend takes it
  a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i && !ready_i |=> valid_i && $stable(burst_i))
    else $error("backend burst dropped or changed while ready_i was low");

  a_one_grant: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(grant_i))
    else $error("more than one port granted in one cycle");

  for (genvar p = 0; p < idma_rt_pkg::NumPorts; p++) begin : gen_port_chk
    a_rsp_ready: assert property (@(posedge clk_i) disable iff (reset_i)
      rsp_i[p].ready |-> req_i[p].valid)
      else $error("register response ready on port %0d without a request", p);
  end

endmodule

/* test/tb_idma_rt_frontend.sv */
// drives both register ports from test/idma_rt_patterns.hex and plays the DMA backend
// run from the project root so the pattern path resolves; test 6 needs no pattern rows
`timescale 1ns/10ps

module tb_idma_rt_frontend;

  localparam int NumRows   = 9;
  localparam int NumCols   = 12;
  localparam int Timeout   = 200;
  localparam int HalfClk   = 4;
  localparam int SampleDly = 2;

  // the seven register values start at ColSrc in register map order
  localparam int ColTest    = 0;
  localparam int ColPort    = 1;
  localparam int ColSrc     = 2;
  localparam int ColExpReps = 9;
  localparam int ColMode    = 10;
  localparam int ColFlags   = 11;

  localparam int ModeProgram = 0;
  localparam int ModeLaunch  = 1;

  logic                                              clk;
  logic                                              reset;
  logic                                              ready;
  logic                                              backend_idle;
  logic                                              trans_complete;
  logic                                              valid;
  idma_rt_pkg::reg_req_t [idma_rt_pkg::NumPorts-1:0] reg_req;
  idma_rt_pkg::reg_rsp_t [idma_rt_pkg::NumPorts-1:0] reg_rsp;
  idma_rt_pkg::burst_req_t                           burst;

  logic [31:0]             pat [0:NumRows*NumCols-1];
  idma_rt_pkg::burst_req_t exp_burst [0:1];
  logic [31:0]             exp_id [0:1];
  logic [31:0]             got_id [0:1];
  int                      slot [0:1];
  logic                    bp_en;
  logic [31:0]             model_next;
  logic [31:0]             model_done;
  int                      exp_cnt;
  int                      acc_cnt;
  int                      acc_base;
  int                      valid_cycles;
  int                      valid_base;
  int                      errors;
  int                      bus_errors;
  int                      tests_run;
  int                      tests_failed;

  idma_rt_frontend dut0 (
    .clk_i            ( clk            ),
    .reset_i          ( reset          ),
    .reg_req_i        ( reg_req        ),
    .ready_i          ( ready          ),
    .backend_idle_i   ( backend_idle   ),
    .trans_complete_i ( trans_complete ),
    .reg_rsp_o        ( reg_rsp        ),
    .burst_req_o      ( burst          ),
    .valid_o          ( valid          )
  );

  bind idma_rt_frontend idma_rt_frontend_chk chk0 (
    .clk_i   ( clk_i        ),
    .reset_i ( reset_i      ),
    .ready_i ( ready_i      ),
    .valid_i ( valid_o      ),
    .burst_i ( burst_req_o  ),
    .grant_i ( launch_grant ),
    .req_i   ( reg_req_i    ),
    .rsp_i   ( reg_rsp_o    )
  );

  initial begin
    clk = 1'b0;
    forever #HalfClk clk = ~clk;
  end

  // the backend model takes a burst whenever valid and ready meet
  initial begin : backend
    int idx;
    ready        = 1'b1;
    acc_cnt      = 0;
    valid_cycles = 0;
    bus_errors   = 0;
    model_next   = 32'd1;
    forever begin
      @(negedge clk);
      ready = bp_en ? (($urandom % 3) != 0) : 1'b1;
      #SampleDly;
      if (valid) valid_cycles++;
      if (valid && ready) begin
        idx = acc_cnt - acc_base;
        if (idx >= exp_cnt) begin
          $display("backend accepted an unexpected burst at %0t", $time);
          bus_errors++;
        end else begin
          assert (burst === exp_burst[idx]) else begin
            $display("Mismatch at %0t: burst %0d is %h, expected %h",
                     $time, idx, burst, exp_burst[idx]);
            bus_errors++;
          end
          exp_id[idx] = model_next;
        end
        model_next++;
        acc_cnt++;
      end
    end
  end

  function automatic logic [31:0] field(input int r, input int c);
    return pat[r * NumCols + c];
  endfunction

  function automatic idma_rt_pkg::burst_req_t row_burst(input int r);
    idma_rt_pkg::burst_req_t b;
    logic [31:0]             flags;
    flags         = field(r, ColFlags);
    b.src_addr    = field(r, ColSrc);
    b.dst_addr    = field(r, ColSrc + 1);
    b.length      = field(r, ColSrc + 2);
    b.src_stride  = field(r, ColSrc + 4);
    b.dst_stride  = field(r, ColSrc + 5);
    b.reps        = field(r, ColExpReps);
    b.decouple_rw = flags[0];
    b.deburst     = flags[1];
    return b;
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout at %0t: %s", $time, why);
    $display(">>> FAIL");
    $finish;
  endtask

  // one register bus access is held until ready and sampled mid low phase
  task automatic reg_access(input int port, input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata, input logic launch,
                            output logic [31:0] rdata, output logic err);
    int waited;
    waited = 0;
    @(negedge clk);
    reg_req[port].valid = 1'b1;
    reg_req[port].write = wr;
    reg_req[port].addr  = addr;
    reg_req[port].wdata = wdata;
    #SampleDly;
    while (!reg_rsp[port].ready && waited < Timeout) begin
      waited++;
      @(negedge clk);
      #SampleDly;
    end
    if (!reg_rsp[port].ready) begin
      abort_run($sformatf("port %0d access to offset %h never got ready", port, addr));
    end else begin
      rdata = reg_rsp[port].rdata;
      err   = reg_rsp[port].error;
      if (launch) begin
        // a launch read completes only together with the backend acceptance
        assert (valid && ready) else begin
          $display("launch read on port %0d completed at %0t without backend acceptance",
                   port, $time);
          errors++;
        end
      end
    end
    @(negedge clk);
    reg_req[port] = '0;
  endtask

  task automatic read_check(input int port, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    reg_access(port, 1'b0, addr, 32'h0, 1'b0, rdata, err);
    check_val(rdata, exp, $sformatf("port %0d offset %h", port, addr));
    check_val({31'b0, err}, 32'd0, $sformatf("error flag, port %0d offset %h", port, addr));
  endtask

  task automatic program_row(input int r);
    int          port;
    logic [7:0]  addr;
    logic [31:0] rdata;
    logic        err;
    port = int'(field(r, ColPort));
    for (int i = 0; i < 7; i++) begin
      addr = idma_rt_pkg::RegSrcAddr + 8'(4 * i);
      reg_access(port, 1'b1, addr, field(r, ColSrc + i), 1'b0, rdata, err);
      check_val({31'b0, err}, 32'd0, $sformatf("write error, port %0d offset %h", port, addr));
      read_check(port, addr, field(r, ColSrc + i));
    end
  endtask

  task automatic check_bad_offsets(input int port);
    logic [31:0] rdata;
    logic        err;
    reg_access(port, 1'b1, 8'h28, 32'hA5A5A5A5, 1'b0, rdata, err);
    check_val({31'b0, err}, 32'd1, "error flag of a write to an unknown offset");
    reg_access(port, 1'b0, 8'h3C, 32'h0, 1'b0, rdata, err);
    check_val(rdata, 32'd0, "read data of an unknown offset");
    check_val({31'b0, err}, 32'd1, "error flag of a read from an unknown offset");
    reg_access(port, 1'b1, idma_rt_pkg::RegDone, 32'h1, 1'b0, rdata, err);
    check_val({31'b0, err}, 32'd1, "error flag of a write to RegDone");
  endtask

  task automatic launch_row(input int r, input int k);
    logic [31:0] rdata;
    logic        err;
    logic        launch;
    launch = (field(r, ColMode) == ModeLaunch);
    reg_access(int'(field(r, ColPort)), 1'b0, idma_rt_pkg::RegNextId, 32'h0, launch,
               rdata, err);
    got_id[k] = rdata;
    check_val({31'b0, err}, 32'd0, "error flag of a next-id read");
    if (!launch) check_val(rdata, 32'd0, "id returned by a refused launch");
  endtask

  task automatic report_test(input int t, input int err_before);
    tests_run++;
    if (errors + bus_errors == err_before) begin
      $display("test %0d passed", t);
    end else begin
      tests_failed++;
      $display("test %0d failed with %0d errors", t, errors + bus_errors - err_before);
    end
  endtask

  task automatic run_test(input int t, input int r0, input int n);
    int err_before;
    int waited;
    err_before = errors + bus_errors;
    for (int k = 0; k < n; k++) program_row(r0 + k);
    if (t == 1) begin
      check_bad_offsets(0);
      check_bad_offsets(1);
    end
    exp_cnt    = 0;
    acc_base   = acc_cnt;
    valid_base = valid_cycles;
    for (int k = 0; k < n; k++) begin
      slot[k] = exp_cnt;
      if (field(r0 + k, ColMode) == ModeLaunch) begin
        exp_burst[exp_cnt] = row_burst(r0 + k);
        exp_cnt++;
      end
    end
    // the backend reads bp_en on the falling edge
    @(posedge clk);
    bp_en = (t == 5);
    // both ports present their next-id read in the same cycle
    fork
      if (field(r0, ColMode) != ModeProgram) launch_row(r0, 0);
      if (n > 1 && field(r0 + 1, ColMode) != ModeProgram) launch_row(r0 + 1, 1);
    join
    waited = 0;
    while (acc_cnt - acc_base < exp_cnt && waited < Timeout) begin
      waited++;
      @(negedge clk);
    end
    if (acc_cnt - acc_base < exp_cnt) begin
      abort_run($sformatf("test %0d bursts never reached the backend", t));
    end
    // quiet window to catch a repeated burst
    repeat (4) @(negedge clk);
    @(posedge clk);
    bp_en = 1'b0;
    check_val(32'(acc_cnt - acc_base), 32'(exp_cnt), "number of accepted bursts");
    if (exp_cnt == 0) check_val(32'(valid_cycles - valid_base), 32'd0, "cycles with valid_o");
    for (int k = 0; k < n; k++) begin
      if (field(r0 + k, ColMode) == ModeLaunch) begin
        check_val(got_id[k], exp_id[slot[k]], $sformatf("id returned for row %0d", r0 + k));
      end
    end
    report_test(t, err_before);
  endtask

  task automatic run_completion_test();
    int err_before;
    int gap;
    err_before = errors + bus_errors;
    read_check(0, idma_rt_pkg::RegDone, model_done);
    @(negedge clk);
    backend_idle = 1'b0;
    read_check(0, idma_rt_pkg::RegStatus, 32'd1);
    read_check(1, idma_rt_pkg::RegStatus, 32'd1);
    @(negedge clk);
    backend_idle = 1'b1;
    read_check(0, idma_rt_pkg::RegStatus, 32'd0);
    read_check(1, idma_rt_pkg::RegStatus, 32'd0);
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      trans_complete = 1'b1;
      @(negedge clk);
      trans_complete = 1'b0;
      model_done++;
      gap = $urandom % 4;
      repeat (gap) @(negedge clk);
    end
    read_check(0, idma_rt_pkg::RegDone, model_done);
    read_check(1, idma_rt_pkg::RegDone, model_done);
    report_test(6, err_before);
  endtask

  initial begin : main
    int r;
    int n;
    void'($urandom(32'h9f9ac965));
    reset          = 1'b1;
    backend_idle   = 1'b1;
    trans_complete = 1'b0;
    reg_req        = '0;
    bp_en          = 1'b0;
    exp_cnt        = 0;
    acc_base       = 0;
    valid_base     = 0;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    model_done     = 32'd0;
    $readmemh("test/idma_rt_patterns.hex", pat);
    repeat (3) @(negedge clk);
    reset = 1'b0;
    r = 0;
    while (r < NumRows) begin
      n = (r + 1 < NumRows && field(r + 1, ColTest) == field(r, ColTest)) ? 2 : 1;
      run_test(int'(field(r, ColTest)), r, n);
      r += n;
    end
    run_completion_test();
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, errors + bus_errors);
    if (errors + bus_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* test/idma_rt_patterns.hex */
// test port src_addr dst_addr num_bytes conf stride_src stride_dst num_reps
// exp_reps mode(0 program, 1 launch, 2 refused) exp_flags(bit0 decouple, bit1 deburst)

// test 1, readback on both ports
01 0 A0001000 B0002000 00000040 00000007 00000010 00000020 00000005 0 0 0
01 1 FFFFFFFF 12345678 DEADBEEF 00000005 CAFEF00D 0BADC0DE 7FFFFFFF 0 0 0

// test 2, 1d launch, reps forced to one
02 1 10000000 20000000 00000100 00000003 00000040 00000080 00000009 1 1 3

// test 3, zero length and 2d with zero repetitions
03 0 30000000 31000000 00000000 00000000 00000000 00000000 00000002 0 2 0
03 1 32000000 33000000 00000080 00000004 00000100 00000200 00000000 0 2 0

// test 4, 2d launches on both ports, port 0 expected first
04 0 40000000 41000000 00000200 00000004 00000400 00000800 00000004 4 1 0
04 1 42000000 43000000 00000020 00000005 00000040 00000040 00000002 2 1 1

// test 5, same under random back-pressure
05 0 50000000 51000000 00000400 00000006 00001000 00002000 00000003 3 1 2
05 1 52000000 53000000 00000010 00000007 00000010 00000010 00000008 8 1 3

/* compile.f */
hw/idma_rt_pkg.sv
hw/idma_burst_arbiter.sv
hw/idma_transfer_id_gen.sv
hw/idma_rt_reg_file.sv
hw/idma_rt_frontend.sv
test/idma_rt_frontend_chk.sv
test/tb_idma_rt_frontend.sv

/* Makefile */
# Verilator flow for the two-port DMA register front end
VERILATOR ?= verilator
TOP       ?= tb_idma_rt_frontend
DUT_TOP   ?= idma_rt_frontend
FILELIST  ?= compile.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SRCS    := $(shell cat $(FILELIST))
RTL     := $(filter hw/%,$(SRCS))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL) --top-module $(DUT_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '>>> FAIL' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
